/* cov_update_top.f */
hw/cov_pkg.sv
hw/cov_update_ctrl.sv
hw/operand_select.sv
hw/mat_mult_engine.sv
hw/matrix_store.sv
hw/cov_update_top.sv
verif/cov_update_checker.sv
verif/cov_update_tb.sv

/* hw/cov_pkg.sv */
// control word shared by the covariance update controller and datapath
// stage values follow the order in which the engine forms the products
`default_nettype none

package cov_pkg;

    // product currently formed by the shared engine
    typedef enum logic [1:0] {
        STG_KR     = 2'd0,
        STG_KRKT   = 2'd1,
        STG_IKHP   = 2'd2,
        STG_JOSEPH = 2'd3
    } stage_t;

    // one word per cycle from the sequencer
    // start, capture and commit are single-cycle pulses
    typedef struct packed {
        stage_t stage;
        logic   start;
        logic   capture;
        logic   commit;
    } stage_cmd_t;

endpackage

`default_nettype wire

/* hw/cov_update_ctrl.sv */
// stage sequencer for the covariance update
// a run starts on a rising edge of ckg_done_i seen while idle, edges during a run are lost
// scu_done_o is held until ckg_done_i is seen low
`timescale 1ns/1ps
`default_nettype none

module cov_update_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ckg_done_i,
    input  logic                eng_done_i,
    output cov_pkg::stage_cmd_t cmd_o,
    output logic                scu_done_o
);
    typedef enum logic [2:0] {
        S_IDLE,
        S_ISSUE,
        S_WAIT,
        S_CAPTURE,
        S_COMMIT,
        S_DONE
    } state_t;

    state_t            state_q;
    cov_pkg::stage_t   stage_q;
    logic              ckg_done_q;
    logic              run_start;

    // ----------------------------------------------------------------------
    // start edge
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ckg_done_q <= 1'b0;
        end else begin
            ckg_done_q <= ckg_done_i;
        end
    end

    assign run_start = ckg_done_i & ~ckg_done_q;

    // ----------------------------------------------------------------------
    // sequencer, each stage is issue, wait for engine, capture
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= S_IDLE;
            stage_q <= cov_pkg::STG_KR;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (run_start) begin
                        stage_q <= cov_pkg::STG_KR;
                        state_q <= S_ISSUE;
                    end
                end
                S_ISSUE: state_q <= S_WAIT;
                S_WAIT: begin
                    if (eng_done_i) begin
                        state_q <= S_CAPTURE;
                    end
                end
                S_CAPTURE: begin
                    if (stage_q == cov_pkg::STG_JOSEPH) begin
                        state_q <= S_COMMIT;
                    end else begin
                        stage_q <= cov_pkg::stage_t'(stage_q + 2'd1);
                        state_q <= S_ISSUE;
                    end
                end
                S_COMMIT: state_q <= S_DONE;
                S_DONE: begin
                    if (!ckg_done_i) begin
                        state_q <= S_IDLE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // command word decoded from the state
    always_comb begin
        cmd_o         = '0;
        cmd_o.stage   = stage_q;
        cmd_o.start   = (state_q == S_ISSUE);
        cmd_o.capture = (state_q == S_CAPTURE);
        cmd_o.commit  = (state_q == S_COMMIT);
    end

    assign scu_done_o = (state_q == S_DONE);

endmodule

`default_nettype wire

/* hw/cov_update_top.sv */
// Joseph-form covariance update, P = K*R*K' + (I-KH)*P*(I-KH)', fixed point
// H selects the first MEAS_DIM states, MEAS_DIM must not exceed STATE_DIM
// k_i, r_i and p_prior_i must stay stable from the ckg_done_i edge to scu_done_o
// words are signed with FRAC_W fractional bits, FRAC_W below DATA_W-1
`timescale 1ns/1ps
`default_nettype none

module cov_update_top #(
    parameter int STATE_DIM = 4,
    parameter int MEAS_DIM  = 2,
    parameter int DATA_W    = 16,
    parameter int FRAC_W    = 8
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic [STATE_DIM*MEAS_DIM*DATA_W-1:0]     k_i,
    input  logic [MEAS_DIM*MEAS_DIM*DATA_W-1:0]      r_i,
    input  logic [STATE_DIM*STATE_DIM*DATA_W-1:0]    p_prior_i,
    input  logic                                     ckg_done_i,
    output logic [STATE_DIM*STATE_DIM*DATA_W-1:0]    p_post_o,
    output logic                                     scu_done_o
);
    localparam int MW = STATE_DIM * STATE_DIM * DATA_W;

    cov_pkg::stage_cmd_t cmd;
    logic                eng_done;
    logic [MW-1:0]       a_mat;
    logic [MW-1:0]       b_mat;
    logic [MW-1:0]       c_mat;
    logic [MW-1:0]       kr_mat;
    logic [MW-1:0]       ikhp_mat;

    cov_update_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .ckg_done_i (ckg_done_i),
        .eng_done_i (eng_done),
        .cmd_o      (cmd),
        .scu_done_o (scu_done_o)
    );

    operand_select #(
        .STATE_DIM (STATE_DIM),
        .MEAS_DIM  (MEAS_DIM),
        .DATA_W    (DATA_W),
        .FRAC_W    (FRAC_W)
    ) u_opsel (
        .k_i       (k_i),
        .r_i       (r_i),
        .p_prior_i (p_prior_i),
        .kr_i      (kr_mat),
        .ikhp_i    (ikhp_mat),
        .cmd_i     (cmd),
        .a_o       (a_mat),
        .b_o       (b_mat)
    );

    mat_mult_engine #(
        .STATE_DIM (STATE_DIM),
        .DATA_W    (DATA_W),
        .FRAC_W    (FRAC_W)
    ) u_engine (
        .clk    (clk),
        .rst_n  (rst_n),
        .cmd_i  (cmd),
        .a_i    (a_mat),
        .b_i    (b_mat),
        .c_o    (c_mat),
        .done_o (eng_done)
    );

    matrix_store #(
        .STATE_DIM (STATE_DIM),
        .DATA_W    (DATA_W)
    ) u_store (
        .clk      (clk),
        .rst_n    (rst_n),
        .cmd_i    (cmd),
        .c_i      (c_mat),
        .kr_o     (kr_mat),
        .ikhp_o   (ikhp_mat),
        .p_post_o (p_post_o)
    );

endmodule

`default_nettype wire

/* hw/mat_mult_engine.sv */
// one multiply-accumulate per cycle, STATE_DIM^3 cycles per product
// a_i and b_i must hold from the start pulse until done_o
// each element is floored by FRAC_W and clamped to the signed word range
`timescale 1ns/1ps
`default_nettype none

module mat_mult_engine #(
    parameter int STATE_DIM = 4,
    parameter int DATA_W    = 16,
    parameter int FRAC_W    = 8
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  cov_pkg::stage_cmd_t                    cmd_i,
    input  logic [STATE_DIM*STATE_DIM*DATA_W-1:0]  a_i,
    input  logic [STATE_DIM*STATE_DIM*DATA_W-1:0]  b_i,
    output logic [STATE_DIM*STATE_DIM*DATA_W-1:0]  c_o,
    output logic                                   done_o
);
    localparam int CW    = (STATE_DIM > 1) ? $clog2(STATE_DIM) : 1;
    localparam int ACC_W = 2 * DATA_W + CW + 1;
    localparam logic [CW-1:0] LAST = CW'(STATE_DIM - 1);
    localparam logic signed [ACC_W-1:0] SAT_HI =
        {{(ACC_W-DATA_W+1){1'b0}}, {(DATA_W-1){1'b1}}};
    localparam logic signed [ACC_W-1:0] SAT_LO = ~SAT_HI;

    logic                     busy_q;
    logic [CW-1:0]            row_q;
    logic [CW-1:0]            col_q;
    logic [CW-1:0]            k_q;
    logic signed [ACC_W-1:0]  acc_q;
    logic signed [DATA_W-1:0] a_el;
    logic signed [DATA_W-1:0] b_el;
    logic signed [ACC_W-1:0]  sum;

    function automatic logic [DATA_W-1:0] sat_shift(input logic signed [ACC_W-1:0] x);
        logic signed [ACC_W-1:0] s;
        s = x >>> FRAC_W;
        if (s > SAT_HI) begin
            s = SAT_HI;
        end else if (s < SAT_LO) begin
            s = SAT_LO;
        end
        return s[DATA_W-1:0];
    endfunction

    // A(row,k) and B(k,col)
    assign a_el = a_i[(row_q*STATE_DIM + k_q)*DATA_W +: DATA_W];
    assign b_el = b_i[(k_q*STATE_DIM + col_q)*DATA_W +: DATA_W];
    assign sum  = acc_q + a_el * b_el;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
            row_q  <= '0;
            col_q  <= '0;
            k_q    <= '0;
            acc_q  <= '0;
            c_o    <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= 1'b0;
            if (cmd_i.start) begin
                busy_q <= 1'b1;
                row_q  <= '0;
                col_q  <= '0;
                k_q    <= '0;
                acc_q  <= '0;
            end else if (busy_q) begin
                if (k_q == LAST) begin
                    // element complete
                    c_o[(row_q*STATE_DIM + col_q)*DATA_W +: DATA_W] <= sat_shift(sum);
                    acc_q <= '0;
                    k_q   <= '0;
                    if (col_q == LAST) begin
                        col_q <= '0;
                        if (row_q == LAST) begin
                            busy_q <= 1'b0;
                            done_o <= 1'b1;
                        end else begin
                            row_q <= row_q + 1'b1;
                        end
                    end else begin
                        col_q <= col_q + 1'b1;
                    end
                end else begin
                    acc_q <= sum;
                    k_q   <= k_q + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/matrix_store.sv */
// intermediate products between stages and the final P_post register
// P_post is the clamped elementwise sum of K*R*K' and the Joseph term
`timescale 1ns/1ps
`default_nettype none

module matrix_store #(
    parameter int STATE_DIM = 4,
    parameter int DATA_W    = 16
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  cov_pkg::stage_cmd_t                    cmd_i,
    input  logic [STATE_DIM*STATE_DIM*DATA_W-1:0]  c_i,
    output logic [STATE_DIM*STATE_DIM*DATA_W-1:0]  kr_o,
    output logic [STATE_DIM*STATE_DIM*DATA_W-1:0]  ikhp_o,
    output logic [STATE_DIM*STATE_DIM*DATA_W-1:0]  p_post_o
);
    localparam int NE = STATE_DIM * STATE_DIM;
    localparam int MW = NE * DATA_W;

    logic [MW-1:0] krkt_q;
    logic [MW-1:0] joseph_q;

    function automatic logic [DATA_W-1:0] sat_add(input logic [DATA_W-1:0] a,
                                                  input logic [DATA_W-1:0] b);
        logic [DATA_W:0] s;
        s = {a[DATA_W-1], a} + {b[DATA_W-1], b};
        // overflow when the two top bits disagree
        if (s[DATA_W] != s[DATA_W-1]) begin
            return s[DATA_W] ? {1'b1, {(DATA_W-1){1'b0}}} : {1'b0, {(DATA_W-1){1'b1}}};
        end
        return s[DATA_W-1:0];
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            kr_o     <= '0;
            krkt_q   <= '0;
            ikhp_o   <= '0;
            joseph_q <= '0;
            p_post_o <= '0;
        end else begin
            if (cmd_i.capture) begin
                case (cmd_i.stage)
                    cov_pkg::STG_KR:   kr_o     <= c_i;
                    cov_pkg::STG_KRKT: krkt_q   <= c_i;
                    cov_pkg::STG_IKHP: ikhp_o   <= c_i;
                    default:           joseph_q <= c_i;
                endcase
            end
            if (cmd_i.commit) begin
                for (int e = 0; e < NE; e++) begin
                    p_post_o[e*DATA_W +: DATA_W] <=
                        sat_add(krkt_q[e*DATA_W +: DATA_W], joseph_q[e*DATA_W +: DATA_W]);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* hw/operand_select.sv */
// operand pairs for the four products, all padded to STATE_DIM x STATE_DIM
// H selects the first MEAS_DIM states, so I-KH only differs from I in its left columns
`timescale 1ns/1ps
`default_nettype none

module operand_select #(
    parameter int STATE_DIM = 4,
    parameter int MEAS_DIM  = 2,
    parameter int DATA_W    = 16,
    parameter int FRAC_W    = 8
) (
    input  logic [STATE_DIM*MEAS_DIM*DATA_W-1:0]   k_i,
    input  logic [MEAS_DIM*MEAS_DIM*DATA_W-1:0]    r_i,
    input  logic [STATE_DIM*STATE_DIM*DATA_W-1:0]  p_prior_i,
    input  logic [STATE_DIM*STATE_DIM*DATA_W-1:0]  kr_i,
    input  logic [STATE_DIM*STATE_DIM*DATA_W-1:0]  ikhp_i,
    input  cov_pkg::stage_cmd_t                    cmd_i,
    output logic [STATE_DIM*STATE_DIM*DATA_W-1:0]  a_o,
    output logic [STATE_DIM*STATE_DIM*DATA_W-1:0]  b_o
);
    localparam int MW = STATE_DIM * STATE_DIM * DATA_W;
    // fixed-point one, one bit wider for the subtraction
    localparam logic [DATA_W:0] ONE_W = (DATA_W+1)'(1) << FRAC_W;

    logic [MW-1:0] k_pad;
    logic [MW-1:0] r_pad;
    logic [MW-1:0] kt_pad;
    logic [MW-1:0] ikh;
    logic [MW-1:0] ikht;

    // clamp a one-bit-wider result back to DATA_W
    function automatic logic [DATA_W-1:0] sat_w(input logic [DATA_W:0] x);
        if (x[DATA_W] != x[DATA_W-1]) begin
            return x[DATA_W] ? {1'b1, {(DATA_W-1){1'b0}}} : {1'b0, {(DATA_W-1){1'b1}}};
        end
        return x[DATA_W-1:0];
    endfunction

    for (genvar gi = 0; gi < STATE_DIM; gi++) begin : g_row
        for (genvar gj = 0; gj < STATE_DIM; gj++) begin : g_col
            localparam int IDX = gi * STATE_DIM + gj;

            if (gj < MEAS_DIM) begin : g_kcol
                logic [DATA_W-1:0] k_el;
                logic [DATA_W:0]   k_ext;
                assign k_el  = k_i[(gi*MEAS_DIM + gj)*DATA_W +: DATA_W];
                assign k_ext = {k_el[DATA_W-1], k_el};
                assign k_pad[IDX*DATA_W +: DATA_W] = k_el;
                // diagonal 1-K(i,i), elsewhere -K(i,j)
                assign ikh[IDX*DATA_W +: DATA_W] = (gi == gj) ? sat_w(ONE_W - k_ext)
                                                               : sat_w(-k_ext);
            end else begin : g_icol
                assign k_pad[IDX*DATA_W +: DATA_W] = '0;
                assign ikh[IDX*DATA_W +: DATA_W]   = (gi == gj) ? sat_w(ONE_W) : '0;
            end

            if (gi < MEAS_DIM && gj < MEAS_DIM) begin : g_r
                assign r_pad[IDX*DATA_W +: DATA_W] = r_i[(gi*MEAS_DIM + gj)*DATA_W +: DATA_W];
            end else begin : g_rz
                assign r_pad[IDX*DATA_W +: DATA_W] = '0;
            end

            // K' occupies the top MEAS_DIM rows
            if (gi < MEAS_DIM) begin : g_kt
                assign kt_pad[IDX*DATA_W +: DATA_W] = k_i[(gj*MEAS_DIM + gi)*DATA_W +: DATA_W];
            end else begin : g_ktz
                assign kt_pad[IDX*DATA_W +: DATA_W] = '0;
            end

            assign ikht[(gj*STATE_DIM + gi)*DATA_W +: DATA_W] = ikh[IDX*DATA_W +: DATA_W];
        end
    end

    always_comb begin
        case (cmd_i.stage)
            cov_pkg::STG_KR: begin
                a_o = k_pad;
                b_o = r_pad;
            end
            cov_pkg::STG_KRKT: begin
                a_o = kr_i;
                b_o = kt_pad;
            end
            cov_pkg::STG_IKHP: begin
                a_o = ikh;
                b_o = p_prior_i;
            end
            default: begin
                a_o = ikhp_i;
                b_o = ikht;
            end
        endcase
    end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# builds the covariance update testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f cov_update_top.f \
    --top-module cov_update_tb \
    -o sim_cov_update

sim_output="$(./obj_dir/sim_cov_update)"
echo "$sim_output"

if grep -q "ALL CHECKS PASSED" <<< "$sim_output"; then
    exit 0
else
    exit 1
fi

/* verif/cov_update_checker.sv */
// watches the covariance update outputs and compares them with expected matrices
// p_post_o is compared on each rising edge of scu_done_o, sampled at the clock edge
`timescale 1ns/1ps
`default_nettype none

module cov_update_checker #(
    parameter int NE     = 16,
    parameter int DATA_W = 16
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 scu_done_i,
    input  logic [NE*DATA_W-1:0] p_post_i,
    input  logic [NE*DATA_W-1:0] exp_i,
    output int                   errors_o,
    output int                   tests_o
);
    int   err_count  = 0;
    int   test_count = 0;
    int   test_errs  = 0;
    logic done_q;

    assign errors_o = err_count;
    assign tests_o  = test_count;

    task automatic compare_matrix(input logic [NE*DATA_W-1:0] expected);
        for (int e = 0; e < NE; e++) begin
            if (p_post_i[e*DATA_W +: DATA_W] !== expected[e*DATA_W +: DATA_W]) begin
                $display("error p_post_o[%0d] expected %h actual %h", e,
                         expected[e*DATA_W +: DATA_W], p_post_i[e*DATA_W +: DATA_W]);
                err_count++;
                test_errs++;
            end
        end
    endtask

    task automatic check_done_level(input logic expected);
        if (scu_done_i !== expected) begin
            $display("error scu_done_o expected %h actual %h", expected, scu_done_i);
            err_count++;
            test_errs++;
        end
    endtask

    task automatic check_reset();
        check_done_level(1'b0);
        compare_matrix('0);
    endtask

    // done must stay up and the result must not move
    task automatic check_hold();
        check_done_level(1'b1);
        compare_matrix(exp_i);
    endtask

    task automatic report_fault(input string msg);
        $display("%0s", msg);
        err_count++;
        test_errs++;
    endtask

    task automatic finish_test(input string name);
        if (test_errs == 0) begin
            $display("test %0s: pass", name);
        end else begin
            $display("test %0s: fail, %0d mismatches", name, test_errs);
        end
        test_count++;
        test_errs = 0;
    endtask

    // result is valid on the first cycle of scu_done_o
    always @(posedge clk) begin
        if (!rst_n) begin
            done_q <= 1'b0;
        end else begin
            if (scu_done_i && !done_q) begin
                compare_matrix(exp_i);
            end
            done_q <= scu_done_i;
        end
    end

endmodule

`default_nettype wire

/* verif/cov_update_golden.hex */
// per test four lines: K (8 words), R (4 words), P_prior (16 words), expected P_post (16)
// words are 16-bit signed, 8 fractional bits, element (i,j) at index i*cols+j
// test 0: K(0,0)=0.5, R=I, P=I
0080 0000 0000 0000 0000 0000 0000 0000
0100 0000 0000 0100
0100 0000 0000 0000 0000 0100 0000 0000 0000 0000 0100 0000 0000 0000 0000 0100
0080 0000 0000 0000 0000 0100 0000 0000 0000 0000 0100 0000 0000 0000 0000 0100
// test 1: large entries, products, 1-K(i,i) and the final sum all saturate
8000 8000 8000 8000 8000 8000 8000 8000
7fff 7fff 7fff 7fff
7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff
7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff
// test 2: gains 0.25 and 0.125, R=2I, P=I, negative off-diagonal terms
0040 0000 0000 0040 0020 0000 0000 0020
0200 0000 0000 0200
0100 0000 0000 0000 0000 0100 0000 0000 0000 0000 0100 0000 0000 0000 0000 0100
00b0 0000 fff8 0000 0000 00b0 0000 fff8 fff8 0000 010c 0000 0000 fff8 0000 010c

/* verif/cov_update_tb.sv */
// testbench for the covariance update, golden vectors plus zero-gain random runs
// golden data is read from verif/cov_update_golden.hex, run from the project root
`timescale 1ns/1ps
`default_nettype none

module cov_update_tb;
    localparam int STATE_DIM  = 4;
    localparam int MEAS_DIM   = 2;
    localparam int DATA_W     = 16;
    localparam int FRAC_W     = 8;
    localparam int NK         = STATE_DIM * MEAS_DIM;
    localparam int NR         = MEAS_DIM * MEAS_DIM;
    localparam int NP         = STATE_DIM * STATE_DIM;
    localparam int TEST_WORDS = NK + NR + 2 * NP;
    localparam int NUM_GOLDEN = 3;
    localparam int NUM_RANDOM = 4;
    localparam int NUM_TESTS  = NUM_GOLDEN + NUM_RANDOM + 2;
    localparam int RUN_CYCLES = 4 * (STATE_DIM**3 + 3);
    localparam int RESET_CYC  = 16;
    localparam int HOLD_CYC   = 20;
    localparam int WDOG_CYC   = NUM_TESTS * 2 * RUN_CYCLES + RESET_CYC;
    localparam int DRIVE_DLY  = 5;

    logic                   clk;
    logic                   rst_n;
    logic [NK*DATA_W-1:0]   k_mat;
    logic [NR*DATA_W-1:0]   r_mat;
    logic [NP*DATA_W-1:0]   p_mat;
    logic [NP*DATA_W-1:0]   exp_mat;
    logic                   ckg_done;
    logic [NP*DATA_W-1:0]   p_post;
    logic                   scu_done;
    logic [DATA_W-1:0]      golden_mem [0:NUM_GOLDEN*TEST_WORDS-1];
    logic [31:0]            seed;
    int                     errors;
    int                     tests;

    cov_update_top #(
        .STATE_DIM (STATE_DIM),
        .MEAS_DIM  (MEAS_DIM),
        .DATA_W    (DATA_W),
        .FRAC_W    (FRAC_W)
    ) UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .k_i        (k_mat),
        .r_i        (r_mat),
        .p_prior_i  (p_mat),
        .ckg_done_i (ckg_done),
        .p_post_o   (p_post),
        .scu_done_o (scu_done)
    );

    cov_update_checker #(
        .NE     (NP),
        .DATA_W (DATA_W)
    ) chk (
        .clk        (clk),
        .rst_n      (rst_n),
        .scu_done_i (scu_done),
        .p_post_i   (p_post),
        .exp_i      (exp_mat),
        .errors_o   (errors),
        .tests_o    (tests)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ----------------------------------------------------------------------
    // watchdog
    // ----------------------------------------------------------------------
    initial begin
        repeat (WDOG_CYC) @(posedge clk);
        $display("watchdog expired after %0d cycles, run did not finish", WDOG_CYC);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic load_golden(input int t);
        int base;
        base = t * TEST_WORDS;
        for (int e = 0; e < NK; e++) k_mat[e*DATA_W +: DATA_W] = golden_mem[base + e];
        for (int e = 0; e < NR; e++) r_mat[e*DATA_W +: DATA_W] = golden_mem[base + NK + e];
        for (int e = 0; e < NP; e++) begin
            p_mat[e*DATA_W +: DATA_W]   = golden_mem[base + NK + NR + e];
            exp_mat[e*DATA_W +: DATA_W] = golden_mem[base + NK + NR + NP + e];
        end
    endtask

    // zero gain, so P_post must equal P_prior
    task automatic load_random();
        k_mat = '0;
        for (int e = 0; e < NR; e++) begin
            seed = lcg_next(seed);
            r_mat[e*DATA_W +: DATA_W] = seed[31:16];
        end
        for (int e = 0; e < NP; e++) begin
            seed = lcg_next(seed);
            p_mat[e*DATA_W +: DATA_W] = seed[31:16];
        end
        exp_mat = p_mat;
    endtask

    task automatic start_and_wait(input string name);
        int cycles;
        cycles   = 0;
        ckg_done = 1'b1;
        while (scu_done !== 1'b1 && cycles < 2 * RUN_CYCLES) begin
            @(posedge clk);
            #DRIVE_DLY;
            cycles++;
        end
        if (scu_done !== 1'b1) begin
            chk.report_fault($sformatf("%0s: scu_done_o never rose", name));
        end else begin
            // checker samples the result on this edge
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    task automatic release_and_wait(input string name);
        int cycles;
        cycles   = 0;
        ckg_done = 1'b0;
        while (scu_done !== 1'b0 && cycles < 4) begin
            @(posedge clk);
            #DRIVE_DLY;
            cycles++;
        end
        if (scu_done !== 1'b0) begin
            chk.report_fault($sformatf("%0s: scu_done_o stayed high after ckg_done_i fell", name));
        end
    endtask

    task automatic run_test(input string name);
        start_and_wait(name);
        release_and_wait(name);
        chk.finish_test(name);
    endtask

    initial begin
        rst_n    = 1'b0;
        ckg_done = 1'b0;
        k_mat    = '0;
        r_mat    = '0;
        p_mat    = '0;
        exp_mat  = '0;
        seed     = 32'he28e;
        $readmemh("verif/cov_update_golden.hex", golden_mem);

        repeat (RESET_CYC) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        @(posedge clk);
        #DRIVE_DLY;
        chk.check_reset();
        chk.finish_test("reset");

        for (int t = 0; t < NUM_GOLDEN; t++) begin
            load_golden(t);
            run_test($sformatf("golden_%0d", t));
        end

        // held start level, changed inputs must not start a second run
        start_and_wait("hold");
        for (int c = 0; c < HOLD_CYC; c++) begin
            p_mat[c%NP*DATA_W +: DATA_W] = DATA_W'(c * 37 + 5);
            @(posedge clk);
            #DRIVE_DLY;
            chk.check_hold();
        end
        release_and_wait("hold");
        chk.finish_test("hold");

        for (int t = 0; t < NUM_RANDOM; t++) begin
            load_random();
            run_test($sformatf("zero_gain_%0d", t));
        end

        $display("tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
